/* sim.f */
+incdir+design
design/exu_pkg.sv
design/exu_operand_mux.sv
design/exu_alu.sv
design/exu_ghr.sv
design/exu_r_stage.sv
design/exu_top.sv
verif/tb_clk_gen.sv
verif/tb_exu.sv

/* verif/tb_exu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exu_settings.svh"

module tb_exu;

   import exu_pkg::*;

   typedef struct packed {
      dec_pkt_t    dec;
      pc_t         pc;
      word_t       imm;
      word_t       br_off;
      word_t       gpr1;
      word_t       gpr2;
      word_t       res_r;
      word_t       lsu_m;
      pred_pkt_t   pred;
      logic        fl;                          // Lower flush while this entry is at D
      pc_t         fl_path;
      logic        chk_res;                     // Expected outputs seen with this entry at D
      word_t       exp_res;
      logic        exp_flush;
      pc_t         exp_path;
      br_report_t  exp_br;
   } entry_t;

   logic        clk;
   logic        arst_n;
   logic        flush_lower_r;
   dec_pkt_t    dec;
   pc_t         pc;
   pc_t         flush_path_r;
   word_t       imm;
   word_t       br_offset;
   word_t       gpr_rs1;
   word_t       gpr_rs2;
   word_t       result_r;
   word_t       lsu_result_m;
   pred_pkt_t   pred;
   word_t       result_x;
   logic        flush_final;
   pc_t         flush_path_final;
   br_report_t  br_r;
   entry_t      tbl[$];
   logic [31:0] lfsr_state;

   tb_clk_gen i_clk_gen (
      .o_clk    (clk),
      .o_arst_n (arst_n)
   );

   exu_top i_exu_top (
      .i_clk              (clk),
      .i_arst_n           (arst_n),
      .i_x_en             (1'b1),
      .i_r_en             (1'b1),
      .i_dec              (dec),
      .i_pc               (pc),
      .i_imm              (imm),
      .i_br_offset        (br_offset),
      .i_gpr_rs1          (gpr_rs1),
      .i_gpr_rs2          (gpr_rs2),
      .i_result_r         (result_r),
      .i_lsu_result_m     (lsu_result_m),
      .i_pred             (pred),
      .i_flush_lower_r    (flush_lower_r),
      .i_flush_path_r     (flush_path_r),
      .o_result_x         (result_x),
      .o_flush_final      (flush_final),
      .o_flush_path_final (flush_path_final),
      .o_br_r             (br_r)
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32,22,2,1
   endfunction

   task automatic rand_word(output word_t w);
      w = '0;
      for (int i = 0; i < `EXU_XLEN; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         w = {w[`EXU_XLEN-2:0], lfsr_state[0]};
      end
   endtask

   function automatic logic cond_ref(input alu_op_e op, input word_t a, input word_t b);
      case (op)
         ALU_BEQ:  return a == b;
         ALU_BNE:  return a != b;
         ALU_BLT:  return $signed(a) < $signed(b);
         ALU_BGE:  return $signed(a) >= $signed(b);
         ALU_BLTU: return a < b;
         ALU_BGEU: return a >= b;
         default:  return 1'b0;
      endcase
   endfunction

   function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b,
                                     input pc_t pc_in);
      int unsigned sh;
      sh = b % `EXU_XLEN;
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_AND:  return a & b;
         ALU_OR:   return a | b;
         ALU_XOR:  return a ^ b;
         ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
         ALU_SLTU: return (a < b) ? 1 : 0;
         ALU_SLL:  return a << sh;
         ALU_SRL:  return a >> sh;
         ALU_SRA:  return $signed(a) >>> sh;
         default:  return pc_in + `EXU_PC_INC;  // Link value
      endcase
   endfunction

   function automatic word_t byp_ref(input byp_sel_t sel, input word_t r, input word_t m,
                                     input word_t x);
      case (sel)
         3'b001:  return r;
         3'b010:  return m;
         3'b100:  return x;
         default: return '0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERR t=%0t %s got %0h exp %0h", $time, name, got, exp);
         $display("tests failed");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   // Modes 0 correct, 1 wrong direction, 2 wrong target, 3 invalid prediction, 4 correct
   task automatic add_entry(input logic v, input alu_op_e op, input logic br,
                            input rs1_sel_e s1, input rs2_sel_e s2, input byp_sel_t b1,
                            input byp_sel_t b2, input int mode, input logic fl);
      entry_t e;
      logic   tk;
      pc_t    tgt;
      e = '0;
      rand_word(e.pc);
      rand_word(e.imm);
      rand_word(e.br_off);
      rand_word(e.gpr1);
      rand_word(e.gpr2);
      rand_word(e.res_r);
      rand_word(e.lsu_m);
      rand_word(e.fl_path);
      e.pc[1:0]      = 2'b00;
      e.br_off[1:0]  = 2'b00;
      e.fl_path[1:0] = 2'b00;
      e.dec.valid    = v;
      e.dec.op       = op;
      e.dec.is_branch = br;
      e.dec.rs1_sel  = s1;
      e.dec.rs2_sel  = s2;
      e.dec.rs1_byp  = b1;
      e.dec.rs2_byp  = b2;
      e.fl           = fl;
      if (br && (mode == 2 || mode == 4)) begin
         e.gpr2 = e.gpr1;                      // Equal operands
      end
      tk  = cond_ref(op, e.gpr1, e.gpr2);
      tgt = e.pc + e.br_off;
      case (mode)
         0, 4:    e.pred = '{valid: tk, taken: tk, target: tgt};
         1:       e.pred = '{valid: 1'b1, taken: ~tk, target: tgt};
         2:       e.pred = '{valid: 1'b1, taken: 1'b1, target: tgt + 8};
         default: e.pred = '{valid: 1'b0, taken: 1'b1, target: tgt};
      endcase
      tbl.push_back(e);
   endtask

   task automatic build_table();
      add_entry(0, ALU_ADD, 0, RS1_ZERO, RS2_ZERO, 3'b000, 3'b000, 0, 0);
      for (int i = 0; i < 10; i++) begin      // ADD up to SRA
         add_entry(1, alu_op_e'(i), 0, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 0, 0);
         add_entry(1, alu_op_e'(i), 0, RS1_GPR, RS2_IMM, 3'b000, 3'b000, 0, 0);
      end
      add_entry(1, ALU_ADD, 0, RS1_PC, RS2_IMM, 3'b000, 3'b000, 0, 0);
      add_entry(1, ALU_OR, 0, RS1_ZERO, RS2_IMM, 3'b000, 3'b000, 0, 0);
      // Bypass from R, LSU M and back-to-back X
      add_entry(1, ALU_ADD, 0, RS1_GPR, RS2_GPR, 3'b001, 3'b010, 0, 0);
      add_entry(1, ALU_SUB, 0, RS1_GPR, RS2_IMM, 3'b100, 3'b001, 0, 0);
      add_entry(1, ALU_XOR, 0, RS1_PC, RS2_GPR, 3'b010, 3'b100, 0, 0);
      for (int i = 10; i < 16; i++) begin
         for (int m = 0; m < 5; m++) begin
            add_entry(1, alu_op_e'(i), 1, RS1_GPR, RS2_GPR, 3'b000, 3'b000, m, 0);
            add_entry(1, ALU_ADD, 0, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 0, 0);
         end
      end
      // Lower flush over a mispredict, a correct branch and an ALU op
      add_entry(1, ALU_BNE, 1, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 1, 0);
      add_entry(1, ALU_ADD, 0, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 0, 1);
      add_entry(1, ALU_BLT, 1, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 0, 0);
      add_entry(1, ALU_BNE, 1, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 1, 1);  // Would mispredict
      add_entry(1, ALU_OR, 0, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 0, 0);
      add_entry(1, ALU_XOR, 0, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 0, 1);
      // Mispredict in X kills a second wrong branch entering X
      add_entry(1, ALU_BEQ, 1, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 1, 0);
      add_entry(1, ALU_BNE, 1, RS1_GPR, RS2_GPR, 3'b000, 3'b000, 1, 0);
      repeat (3) add_entry(0, ALU_ADD, 0, RS1_ZERO, RS2_ZERO, 3'b000, 3'b000, 0, 0);
   endtask

   // Cycle model of X and R, one table entry per clock edge
   task automatic compute_expected();
      logic       xv = 1'b0;
      logic       xbr = 1'b0;
      alu_op_e    op = ALU_ADD;
      word_t      a = '0;
      word_t      b = '0;
      pc_t        xpc = '0;
      pc_t        tgt = '0;
      pred_pkt_t  xpred = '0;
      ghr_t       ghr = '0;
      br_report_t rep = '0;
      word_t      res;
      logic       bv;
      logic       tk;
      logic       mis;
      pc_t        npc;
      entry_t     e;
      foreach (tbl[k]) begin
         e   = tbl[k];
         res = alu_ref(op, a, b, xpc);
         bv  = xv & xbr;
         tk  = bv & cond_ref(op, a, b);
         mis = bv & ((tk != (xpred.valid & xpred.taken)) | (tk & (xpred.target != tgt)));
         npc = tk ? tgt : xpc + `EXU_PC_INC;
         e.chk_res   = xv;
         e.exp_res   = res;
         e.exp_flush = e.fl | mis;
         e.exp_path  = e.fl ? e.fl_path : npc;
         e.exp_br    = rep;
         tbl[k]      = e;
         if (bv && !e.fl) begin
            ghr = {ghr[`EXU_GHR_SIZE-2:0], tk};
         end
         rep = '{valid: bv & ~e.fl, taken: tk, mispredict: mis, npc: npc, ghr: ghr};
         xv  = e.dec.valid & ~(e.fl | mis);
         xbr = e.dec.is_branch;
         op  = e.dec.op;
         a   = (|e.dec.rs1_byp) ? byp_ref(e.dec.rs1_byp, e.res_r, e.lsu_m, res) :
               (e.dec.rs1_sel == RS1_GPR) ? e.gpr1 : (e.dec.rs1_sel == RS1_PC) ? e.pc : '0;
         b   = (|e.dec.rs2_byp) ? byp_ref(e.dec.rs2_byp, e.res_r, e.lsu_m, res) :
               (e.dec.rs2_sel == RS2_GPR) ? e.gpr2 : (e.dec.rs2_sel == RS2_IMM) ? e.imm : '0;
         xpc   = e.pc;
         tgt   = e.pc + e.br_off;
         xpred = e.pred;
      end
   endtask

   task automatic drive_entry(input entry_t e);
      dec           = e.dec;
      pc            = e.pc;
      imm           = e.imm;
      br_offset     = e.br_off;
      gpr_rs1       = e.gpr1;
      gpr_rs2       = e.gpr2;
      result_r      = e.res_r;
      lsu_result_m  = e.lsu_m;
      pred          = e.pred;
      flush_lower_r = e.fl;
      flush_path_r  = e.fl_path;
   endtask

   initial begin
      int waited;
      lfsr_state = 32'h2088e08b;
      waited     = 0;
      drive_entry('0);
      build_table();
      compute_expected();
      while (arst_n !== 1'b1) begin
         @(negedge clk);
         waited++;
         if (waited > 10) begin
            $display("tests failed");
            $fatal(1, "Reset was not released within 10 clock cycles");
         end
      end
      #2;
      check_value("o_flush_final", flush_final, 0);
      check_value("o_br_r.valid", br_r.valid, 0);
      foreach (tbl[k]) begin
         @(negedge clk);
         drive_entry(tbl[k]);
         #2;                                   // Settle before sampling
         if (tbl[k].chk_res) begin
            check_value("o_result_x", result_x, tbl[k].exp_res);
         end
         check_value("o_flush_final", flush_final, tbl[k].exp_flush);
         if (tbl[k].exp_flush) begin
            check_value("o_flush_path_final", flush_path_final, tbl[k].exp_path);
         end
         check_value("o_br_r.valid", br_r.valid, tbl[k].exp_br.valid);
         if (tbl[k].exp_br.valid) begin
            check_value("o_br_r", br_r, tbl[k].exp_br);
         end
      end
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic o_clk,
   output logic o_arst_n
);

   initial begin
      o_clk = 1'b0;
      forever #10 o_clk = ~o_clk;              // 20 ns period
   end

   initial begin
      o_arst_n = 1'b0;
      repeat (2) @(posedge o_clk);
      #5 o_arst_n = 1'b1;                      // Release away from both edges
   end

endmodule

`default_nettype wire

/* design/exu_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exu_settings.svh"

module exu_top (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  logic                 i_x_en,           // D to X advance
   input  logic                 i_r_en,           // X to R advance
   input  exu_pkg::dec_pkt_t    i_dec,
   input  exu_pkg::pc_t         i_pc,
   input  exu_pkg::word_t       i_imm,
   input  exu_pkg::word_t       i_br_offset,
   input  exu_pkg::word_t       i_gpr_rs1,
   input  exu_pkg::word_t       i_gpr_rs2,
   input  exu_pkg::word_t       i_result_r,
   input  exu_pkg::word_t       i_lsu_result_m,
   input  exu_pkg::pred_pkt_t   i_pred,
   input  logic                 i_flush_lower_r,
   input  exu_pkg::pc_t         i_flush_path_r,
   output exu_pkg::word_t       o_result_x,
   output logic                 o_flush_final,
   output exu_pkg::pc_t         o_flush_path_final,
   output exu_pkg::br_report_t  o_br_r
);

   import exu_pkg::*;

   word_t  rs1_d;
   word_t  rs2_d;
   logic   kill_d;
   logic   mispredict_x;
   logic   taken_x;
   logic   branch_valid_x;
   pc_t    npc_x;
   ghr_t   ghr_x;

   exu_operand_mux i_operand_mux (
      .i_dec          (i_dec),
      .i_pc           (i_pc),
      .i_imm          (i_imm),
      .i_gpr_rs1      (i_gpr_rs1),
      .i_gpr_rs2      (i_gpr_rs2),
      .i_result_r     (i_result_r),
      .i_lsu_result_m (i_lsu_result_m),
      .i_result_x     (o_result_x),          // Back-to-back bypass
      .o_rs1          (rs1_d),
      .o_rs2          (rs2_d)
   );

   // Either flush source empties D
   assign kill_d = i_flush_lower_r | mispredict_x;

   exu_alu i_alu (
      .i_clk            (i_clk),
      .i_arst_n         (i_arst_n),
      .i_x_en           (i_x_en),
      .i_kill           (kill_d),
      .i_dec            (i_dec),
      .i_rs1            (rs1_d),
      .i_rs2            (rs2_d),
      .i_pc             (i_pc),
      .i_br_offset      (i_br_offset),
      .i_pred           (i_pred),
      .o_result_x       (o_result_x),
      .o_mispredict_x   (mispredict_x),
      .o_taken_x        (taken_x),
      .o_branch_valid_x (branch_valid_x),
      .o_npc_x          (npc_x)
   );

   exu_ghr i_ghr (
      .i_clk            (i_clk),
      .i_arst_n         (i_arst_n),
      .i_x_en           (i_x_en),
      .i_flush_lower_r  (i_flush_lower_r),
      .i_mispredict_x   (mispredict_x),
      .i_d_branch       (i_dec.valid & i_dec.is_branch),
      .i_d_pred_taken   (i_pred.valid & i_pred.taken),
      .i_branch_valid_x (branch_valid_x),
      .i_taken_x        (taken_x),
      .o_ghr_x          (ghr_x)
   );

   exu_r_stage i_r_stage (
      .i_clk            (i_clk),
      .i_arst_n         (i_arst_n),
      .i_r_en           (i_r_en),
      .i_flush_lower_r  (i_flush_lower_r),
      .i_branch_valid_x (branch_valid_x),
      .i_taken_x        (taken_x),
      .i_mispredict_x   (mispredict_x),
      .i_npc_x          (npc_x),
      .i_ghr_x          (ghr_x),
      .o_br_r           (o_br_r)
   );

   // Older flush from R takes priority
   assign o_flush_final      = i_flush_lower_r | mispredict_x;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r : npc_x;

endmodule

`default_nettype wire

/* design/exu_r_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exu_settings.svh"

module exu_r_stage (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  logic                 i_r_en,
   input  logic                 i_flush_lower_r,
   input  logic                 i_branch_valid_x,
   input  logic                 i_taken_x,
   input  logic                 i_mispredict_x,
   input  exu_pkg::pc_t         i_npc_x,
   input  exu_pkg::ghr_t        i_ghr_x,
   output exu_pkg::br_report_t  o_br_r
);

   import exu_pkg::*;

   logic  valid_r;
   logic  taken_r;
   logic  mispredict_r;
   pc_t   npc_r;
   ghr_t  ghr_r;

   // Report status, the lower flush drops the X branch
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         valid_r      <= 1'b0;
         taken_r      <= 1'b0;
         mispredict_r <= 1'b0;
      end else if (i_r_en) begin
         valid_r      <= i_branch_valid_x & ~i_flush_lower_r;
         taken_r      <= i_taken_x;
         mispredict_r <= i_mispredict_x & ~i_flush_lower_r;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_r_en) begin
         npc_r <= i_npc_x;                     // Correct next PC either way
         ghr_r <= i_ghr_x;
      end
   end

   always_comb begin
      o_br_r            = '0;
      o_br_r.valid      = valid_r;
      o_br_r.taken      = taken_r;
      o_br_r.mispredict = mispredict_r;
      o_br_r.npc        = npc_r;
      o_br_r.ghr        = ghr_r;
   end

endmodule

`default_nettype wire

/* design/exu_ghr.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exu_settings.svh"

module exu_ghr (
   input  logic           i_clk,
   input  logic           i_arst_n,
   input  logic           i_x_en,
   input  logic           i_flush_lower_r,
   input  logic           i_mispredict_x,
   input  logic           i_d_branch,         // Valid branch at D
   input  logic           i_d_pred_taken,
   input  logic           i_branch_valid_x,
   input  logic           i_taken_x,
   output exu_pkg::ghr_t  o_ghr_x             // X history after this branch
);

   import exu_pkg::*;

   ghr_t  ghr_d;
   ghr_t  ghr_d_ns;
   ghr_t  ghr_x;
   ghr_t  ghr_x_ns;
   logic  flush;

   assign flush = i_flush_lower_r | i_mispredict_x;

   // A branch killed by the lower flush never resolves
   assign ghr_x_ns = (i_branch_valid_x & ~i_flush_lower_r) ?
                     {ghr_x[`EXU_GHR_SIZE-2:0], i_taken_x} : ghr_x;

   always_comb begin
      if (flush) begin
         ghr_d_ns = ghr_x_ns;                  // Restore speculative history
      end else if (i_d_branch) begin
         ghr_d_ns = {ghr_d[`EXU_GHR_SIZE-2:0], i_d_pred_taken};
      end else begin
         ghr_d_ns = ghr_d;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ghr_d <= '0;
         ghr_x <= '0;
      end else if (i_x_en) begin
         ghr_d <= ghr_d_ns;
         ghr_x <= ghr_x_ns;
      end
   end

   assign o_ghr_x = ghr_x_ns;

endmodule

`default_nettype wire

/* design/exu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exu_settings.svh"

module exu_alu (
   input  logic                i_clk,
   input  logic                i_arst_n,
   input  logic                i_x_en,
   input  logic                i_kill,            // Flush, D instruction enters X invalid
   input  exu_pkg::dec_pkt_t   i_dec,
   input  exu_pkg::word_t      i_rs1,
   input  exu_pkg::word_t      i_rs2,
   input  exu_pkg::pc_t        i_pc,
   input  exu_pkg::word_t      i_br_offset,
   input  exu_pkg::pred_pkt_t  i_pred,
   output exu_pkg::word_t      o_result_x,
   output logic                o_mispredict_x,
   output logic                o_taken_x,
   output logic                o_branch_valid_x,
   output exu_pkg::pc_t        o_npc_x
);

   import exu_pkg::*;

   logic       valid_x;
   logic       is_branch_x;
   alu_op_e    op_x;
   pred_pkt_t  pred_x;
   word_t      a_x;
   word_t      b_x;
   pc_t        pc_x;
   pc_t        target_x;
   pc_t        pc_seq_x;
   logic       eq_x;
   logic       lt_x;
   logic       ltu_x;
   logic       cond_x;
   logic       pred_taken_x;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         valid_x     <= 1'b0;
         is_branch_x <= 1'b0;
         op_x        <= ALU_ADD;
         pred_x      <= '0;
      end else if (i_x_en) begin
         valid_x     <= i_dec.valid & ~i_kill;
         is_branch_x <= i_dec.is_branch;
         op_x        <= i_dec.op;
         pred_x      <= i_pred;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_x_en) begin
         a_x      <= i_rs1;
         b_x      <= i_rs2;
         pc_x     <= i_pc;
         target_x <= i_pc + i_br_offset;       // Branch target formed at D
      end
   end

   assign pc_seq_x = pc_x + `EXU_PC_INC;        // Link value and fall-through PC

   assign eq_x  = (a_x == b_x);
   assign lt_x  = ($signed(a_x) < $signed(b_x));
   assign ltu_x = (a_x < b_x);

   always_comb begin
      case (op_x)
         ALU_ADD:  o_result_x = a_x + b_x;
         ALU_SUB:  o_result_x = a_x - b_x;
         ALU_AND:  o_result_x = a_x & b_x;
         ALU_OR:   o_result_x = a_x | b_x;
         ALU_XOR:  o_result_x = a_x ^ b_x;
         ALU_SLT:  o_result_x = word_t'(lt_x);
         ALU_SLTU: o_result_x = word_t'(ltu_x);
         ALU_SLL:  o_result_x = a_x << b_x[$clog2(`EXU_XLEN)-1:0];
         ALU_SRL:  o_result_x = a_x >> b_x[$clog2(`EXU_XLEN)-1:0];
         ALU_SRA:  o_result_x = word_t'($signed(a_x) >>> b_x[$clog2(`EXU_XLEN)-1:0]);
         default:  o_result_x = pc_seq_x;      // Branch ops
      endcase
   end

   always_comb begin
      case (op_x)
         ALU_BEQ:  cond_x = eq_x;
         ALU_BNE:  cond_x = ~eq_x;
         ALU_BLT:  cond_x = lt_x;
         ALU_BGE:  cond_x = ~lt_x;
         ALU_BLTU: cond_x = ltu_x;
         ALU_BGEU: cond_x = ~ltu_x;
         default:  cond_x = 1'b0;
      endcase
   end

   assign o_branch_valid_x = valid_x & is_branch_x;
   assign o_taken_x        = o_branch_valid_x & cond_x;

   // An invalid prediction counts as not taken
   assign pred_taken_x     = pred_x.valid & pred_x.taken;

   assign o_mispredict_x   = o_branch_valid_x &
                             ((o_taken_x != pred_taken_x) |
                              (o_taken_x & (pred_x.target != target_x)));

   assign o_npc_x          = o_taken_x ? target_x : pc_seq_x;

endmodule

`default_nettype wire

/* design/exu_operand_mux.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exu_settings.svh"

module exu_operand_mux (
   input  exu_pkg::dec_pkt_t  i_dec,
   input  exu_pkg::pc_t       i_pc,
   input  exu_pkg::word_t     i_imm,
   input  exu_pkg::word_t     i_gpr_rs1,
   input  exu_pkg::word_t     i_gpr_rs2,
   input  exu_pkg::word_t     i_result_r,
   input  exu_pkg::word_t     i_lsu_result_m,
   input  exu_pkg::word_t     i_result_x,
   output exu_pkg::word_t     o_rs1,
   output exu_pkg::word_t     o_rs2
);

   import exu_pkg::*;

   // AND-OR of the bypass sources, select is one-hot or zero
   function automatic word_t byp_data(input byp_sel_t sel, input word_t res_r,
                                      input word_t lsu_m, input word_t res_x);
      byp_data = ({`EXU_XLEN{sel[0]}} & res_r) |
                 ({`EXU_XLEN{sel[1]}} & lsu_m) |
                 ({`EXU_XLEN{sel[2]}} & res_x);
   endfunction

   always_comb begin
      if (|i_dec.rs1_byp) begin                // Bypass wins over the source select
         o_rs1 = byp_data(i_dec.rs1_byp, i_result_r, i_lsu_result_m, i_result_x);
      end else begin
         case (i_dec.rs1_sel)
            RS1_GPR: o_rs1 = i_gpr_rs1;
            RS1_PC:  o_rs1 = i_pc;              // For auipc and jal
            default: o_rs1 = '0;
         endcase
      end
   end

   always_comb begin
      if (|i_dec.rs2_byp) begin
         o_rs2 = byp_data(i_dec.rs2_byp, i_result_r, i_lsu_result_m, i_result_x);
      end else begin
         case (i_dec.rs2_sel)
            RS2_GPR: o_rs2 = i_gpr_rs2;
            RS2_IMM: o_rs2 = i_imm;
            default: o_rs2 = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/exu_pkg.sv */
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

   typedef logic [`EXU_XLEN-1:0]     word_t;      // Data word
   typedef logic [`EXU_XLEN-1:0]     pc_t;        // Instruction address, bit 0 always zero
   typedef logic [`EXU_GHR_SIZE-1:0] ghr_t;       // Branch history
   typedef logic [2:0]               byp_sel_t;   // One-hot {X, LSU M, R}

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLL,
      ALU_SRL, ALU_SRA, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
   } alu_op_e;

   typedef enum logic [1:0] {
      RS1_ZERO, RS1_GPR, RS1_PC
   } rs1_sel_e;

   typedef enum logic [1:0] {
      RS2_ZERO, RS2_GPR, RS2_IMM
   } rs2_sel_e;

   typedef struct packed {
      logic      valid;
      alu_op_e   op;
      logic      is_branch;
      rs1_sel_e  rs1_sel;
      rs2_sel_e  rs2_sel;
      byp_sel_t  rs1_byp;
      byp_sel_t  rs2_byp;
   } dec_pkt_t;

   typedef struct packed {
      logic      valid;
      logic      taken;
      pc_t       target;
   } pred_pkt_t;

   typedef struct packed {
      logic      valid;
      logic      taken;
      logic      mispredict;
      pc_t       npc;       // Actual next PC of the branch
      ghr_t      ghr;       // History including this branch
   } br_report_t;

endpackage

`default_nettype wire

/* design/exu_settings.svh */
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// Datapath width of the integer pipe
`define EXU_XLEN       32

// Global branch history length, newest outcome in bit 0
`define EXU_GHR_SIZE   8

// Size of a sequential (uncompressed) instruction
`define EXU_PC_INC     4

`endif
